/* design/branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_unit
#(
    parameter int INSN_BYTES = 4
)
(
    input  wire ex_stage_pkg::br_kind_t kind,
    input  wire                         cond_branch,
    input  wire                         jump,
    input  wire                         jump_reg,
    input  wire ex_stage_pkg::xlen_t    cmp1,
    input  wire ex_stage_pkg::xlen_t    cmp2,
    input  wire ex_stage_pkg::xlen_t    base,
    input  wire ex_stage_pkg::xlen_t    offset,
    input  wire ex_stage_pkg::xlen_t    pc,
    input  wire                         squash,
    output logic                        jump_final,
    redirect_if.branch                  redir
);

    import ex_stage_pkg::*;

    logic lt_s;
    logic lt_u;
    logic eq;
    logic cond;

    assign eq   = (cmp1 == cmp2);
    assign lt_s = ($signed(cmp1) < $signed(cmp2));
    assign lt_u = (cmp1 < cmp2);

    always_comb
    begin
        case (kind)
            br_beq:  cond = eq;
            br_bne:  cond = !eq;
            br_blt:  cond = lt_s;
            br_bge:  cond = !lt_s;
            br_bltu: cond = lt_u;
            br_bgeu: cond = !lt_u;
            default: cond = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Resolution towards the flush control

    assign redir.taken        = cond_branch ? cond : (jump | jump_reg);
    assign redir.target       = base + offset;
    assign redir.fall_through = pc + xlen_t'(INSN_BYTES);
    assign redir.ex_pc        = pc;

    // No jump leaves the stage while the pipe is squashed
    assign jump_final = redir.taken & !squash;

endmodule

`default_nettype wire

/* design/ex_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_alu
(
    input  wire ex_stage_pkg::alu_op_t op,
    input  wire                        word_op,
    input  wire ex_stage_pkg::xlen_t   a,
    input  wire ex_stage_pkg::xlen_t   b,
    output ex_stage_pkg::xlen_t        result
);

    import ex_stage_pkg::*;

    function automatic xlen_t sext_word(input word_t w);
        return {{32{w[31]}}, w};
    endfunction

    ////////////////////////////////////////////////////////////
    // 64-bit path

    xlen_t add64;
    xlen_t sub64;
    xlen_t sll64;
    xlen_t srl64;
    xlen_t sra64;

    assign add64 = a + b;
    assign sub64 = b - a;
    assign sll64 = b << a[5:0];
    assign srl64 = b >> a[5:0];
    assign sra64 = $signed(b) >>> a[5:0];

    ////////////////////////////////////////////////////////////
    // Word path with a 5-bit shift amount

    word_t add32;
    word_t sub32;
    word_t sll32;
    word_t srl32;
    word_t sra32;

    assign add32 = a[31:0] + b[31:0];
    assign sub32 = b[31:0] - a[31:0];
    assign sll32 = b[31:0] << a[4:0];
    assign srl32 = b[31:0] >> a[4:0];
    assign sra32 = $signed(b[31:0]) >>> a[4:0];

    always_comb
    begin
        case (op)
            alu_add:    result = word_op ? sext_word(add32) : add64;
            alu_sub:    result = word_op ? sext_word(sub32) : sub64;
            alu_sll:    result = word_op ? sext_word(sll32) : sll64;
            alu_srl:    result = word_op ? sext_word(srl32) : srl64;
            alu_sra:    result = word_op ? sext_word(sra32) : sra64;
            alu_xor:    result = a ^ b;
            alu_or:     result = a | b;
            alu_and:    result = a & b;
            alu_pass_a: result = a;
            alu_pass_b: result = b;
            // Comparisons are b against a
            alu_slt:    result = {63'd0, $signed(b) < $signed(a)};
            alu_sltu:   result = {63'd0, b < a};
            alu_b4:     result = b + 64'd4;
            default:    result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_stage
#(
    parameter int FLUSH_HOLD  = 3,
    parameter int SQUASH_HOLD = 5,
    parameter int INSN_BYTES  = 4
)
(
    input  wire                           CLK,
    input  wire                           RST,
    input  wire ex_stage_pkg::alu_op_t    alu_op,
    input  wire                           word_op,
    input  wire ex_stage_pkg::xlen_t      op_a,
    input  wire ex_stage_pkg::xlen_t      op_b,
    input  wire ex_stage_pkg::xlen_t      cmp1,
    input  wire ex_stage_pkg::xlen_t      cmp2,
    input  wire ex_stage_pkg::xlen_t      jump_base,
    input  wire ex_stage_pkg::xlen_t      jump_offset,
    input  wire ex_stage_pkg::xlen_t      pc_ex,
    input  wire ex_stage_pkg::xlen_t      next_pc,
    input  wire ex_stage_pkg::br_kind_t   br_kind,
    input  wire                           cond_branch,
    input  wire                           jump,
    input  wire                           jump_reg,
    input  wire                           stall_check,
    input  wire                           cache_ready,
    input  wire ex_stage_pkg::mem_ctl_t   mem_ctl_in,
    input  wire ex_stage_pkg::mem_type_t  mem_type_in,
    input  wire ex_stage_pkg::ldst_size_t ldst_size,
    output ex_stage_pkg::xlen_t           alu_result,
    output ex_stage_pkg::xlen_t           data_address,
    output ex_stage_pkg::xlen_t           jump_addr,
    output logic                          jump_final,
    output logic                          flush,
    output logic                          squash,
    output logic                          predicted,
    output ex_stage_pkg::mem_ctl_t        mem_ctl,
    output ex_stage_pkg::mem_type_t       mem_type,
    output logic                          word_op_out,
    output logic                          load_misaligned,
    output logic                          store_misaligned,
    output logic                          load_word
);

    import ex_stage_pkg::*;

    redirect_if redir ();

    ex_alu alu_inst
    (
        .op      (alu_op),
        .word_op (word_op),
        .a       (op_a),
        .b       (op_b),
        .result  (alu_result)
    );

    branch_unit #(.INSN_BYTES(INSN_BYTES)) branch_inst
    (
        .kind        (br_kind),
        .cond_branch (cond_branch),
        .jump        (jump),
        .jump_reg    (jump_reg),
        .cmp1        (cmp1),
        .cmp2        (cmp2),
        .base        (jump_base),
        .offset      (jump_offset),
        .pc          (pc_ex),
        .squash      (squash),
        .jump_final  (jump_final),
        .redir       (redir.branch)
    );

    flush_control #(.FLUSH_HOLD(FLUSH_HOLD), .SQUASH_HOLD(SQUASH_HOLD)) flush_inst
    (
        .CLK         (CLK),
        .RST         (RST),
        .cache_ready (cache_ready),
        .stall_check (stall_check),
        .next_pc     (next_pc),
        .redir       (redir.control),
        .flush       (flush),
        .squash      (squash),
        .predicted   (predicted)
    );

    mem_align_check align_inst
    (
        .ctl              (mem_ctl_in),
        .size             (ldst_size),
        .base             (op_a),
        .offset           (op_b),
        .address          (data_address),
        .load_misaligned  (load_misaligned),
        .store_misaligned (store_misaligned)
    );

    ////////////////////////////////////////////////////////////
    // Side effects are dropped while squashed

    assign jump_addr   = redir.target;
    assign mem_ctl     = squash ? mem_none : mem_ctl_in;
    assign mem_type    = squash ? mem_type_t'(2'b00) : mem_type_in;
    assign word_op_out = word_op & !squash;
    assign load_word   = (ldst_size != ls_double);

endmodule

`default_nettype wire

/* design/ex_stage_pkg.sv */
`default_nettype none

package ex_stage_pkg;

    typedef logic [63:0] xlen_t;
    typedef logic [31:0] word_t;

    typedef enum logic [3:0]
    {
        alu_idle   = 4'd0,
        alu_add    = 4'd1,
        alu_sub    = 4'd2,
        alu_sll    = 4'd3,
        alu_srl    = 4'd4,
        alu_sra    = 4'd5,
        alu_xor    = 4'd6,
        alu_or     = 4'd7,
        alu_and    = 4'd8,
        alu_pass_a = 4'd9,
        alu_pass_b = 4'd10,
        alu_slt    = 4'd11,
        alu_sltu   = 4'd12,
        alu_b4     = 4'd13
    } alu_op_t;

    // funct3 of the branch; codes 2 and 3 never take
    typedef enum logic [2:0]
    {
        br_beq  = 3'd0,
        br_bne  = 3'd1,
        br_blt  = 3'd4,
        br_bge  = 3'd5,
        br_bltu = 3'd6,
        br_bgeu = 3'd7
    } br_kind_t;

    typedef enum logic [1:0]
    {
        mem_none  = 2'd0,
        mem_load  = 2'd1,
        mem_store = 2'd2
    } mem_ctl_t;

    // Same codes for loads and stores
    typedef enum logic [2:0]
    {
        ls_byte   = 3'd0,
        ls_half   = 3'd1,
        ls_uhalf  = 3'd2,
        ls_word   = 3'd3,
        ls_uword  = 3'd4,
        ls_double = 3'd5
    } ldst_size_t;

    typedef logic [1:0] mem_type_t;

    typedef enum logic [1:0]
    {
        rs_idle,
        rs_flushing,
        rs_squashing
    } redir_state_t;

endpackage

`default_nettype wire

/* design/flush_control.sv */
`timescale 1ns/1ps
`default_nettype none

module flush_control
#(
    parameter int FLUSH_HOLD  = 3,
    parameter int SQUASH_HOLD = 5
)
(
    input  wire                      CLK,
    input  wire                      RST,
    input  wire                      cache_ready,
    input  wire                      stall_check,
    input  wire ex_stage_pkg::xlen_t next_pc,
    redirect_if.control              redir,
    output logic                     flush,
    output logic                     squash,
    output logic                     predicted
);

    import ex_stage_pkg::*;

    localparam int CNT_W = $clog2(SQUASH_HOLD + 2);

    redir_state_t     state;
    logic [CNT_W-1:0] flush_cnt;
    logic [CNT_W-1:0] squash_cnt;
    logic             ready_seen;
    logic             warm;

    logic  jump_miss;
    logic  seq_miss;
    logic  mispredict;
    xlen_t next_step;
    xlen_t seq_step;

    // Offsets from the execute PC
    assign next_step = next_pc - redir.ex_pc;
    assign seq_step  = redir.fall_through - redir.ex_pc;

    assign jump_miss  = redir.taken & !squash & (next_pc != redir.target);
    assign seq_miss   = stall_check & !squash & warm & (next_step != seq_step);
    assign mispredict = jump_miss | seq_miss;

    assign predicted = !(cache_ready & warm & mispredict);

    assign flush  = (state == rs_flushing);
    assign squash = (state != rs_idle);

    ////////////////////////////////////////////////////////////
    // Everything holds while the cache is not ready

    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            state      <= rs_idle;
            flush_cnt  <= '0;
            squash_cnt <= '0;
            ready_seen <= 1'b0;
            warm       <= 1'b0;
        end
        else if (cache_ready)
        begin
            ready_seen <= 1'b1;
            warm       <= ready_seen;
            if (mispredict)
            begin
                state      <= rs_flushing;
                flush_cnt  <= '0;
                squash_cnt <= '0;
            end
            else
            begin
                case (state)
                    rs_flushing:
                    begin
                        flush_cnt  <= flush_cnt + 1'b1;
                        squash_cnt <= squash_cnt + 1'b1;
                        if (flush_cnt == CNT_W'(FLUSH_HOLD))
                            state <= rs_squashing;
                    end
                    rs_squashing:
                    begin
                        squash_cnt <= squash_cnt + 1'b1;
                        if (squash_cnt == CNT_W'(SQUASH_HOLD))
                            state <= rs_idle;
                    end
                    default:
                    begin
                        state <= rs_idle;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* design/mem_align_check.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_align_check
(
    input  wire ex_stage_pkg::mem_ctl_t   ctl,
    input  wire ex_stage_pkg::ldst_size_t size,
    input  wire ex_stage_pkg::xlen_t      base,
    input  wire ex_stage_pkg::xlen_t      offset,
    output ex_stage_pkg::xlen_t           address,
    output logic                          load_misaligned,
    output logic                          store_misaligned
);

    import ex_stage_pkg::*;

    logic [2:0] low;
    logic       misaligned;

    assign address = xlen_t'($signed(base) + $signed(offset));
    assign low     = address[2:0];

    // Accesses only fault when they cross a double-word
    always_comb
    begin
        case (size)
            ls_half,
            ls_uhalf:  misaligned = &low;
            ls_word,
            ls_uword:  misaligned = (low > 3'd4);
            ls_double: misaligned = |low;
            default:   misaligned = 1'b0;
        endcase
    end

    assign load_misaligned  = (ctl == mem_load) & misaligned;
    assign store_misaligned = (ctl == mem_store) & misaligned;

endmodule

`default_nettype wire

/* design/redirect_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface redirect_if;

    import ex_stage_pkg::*;

    logic  taken;
    xlen_t target;
    xlen_t fall_through;
    xlen_t ex_pc;

    modport branch
    (
        output taken,
        output target,
        output fall_through,
        output ex_pc
    );

    modport control
    (
        input taken,
        input target,
        input fall_through,
        input ex_pc
    );

endinterface

`default_nettype wire

/* ex_stage.f */
+incdir+sim
design/ex_stage_pkg.sv
design/redirect_if.sv
design/ex_alu.sv
design/branch_unit.sv
design/flush_control.sv
design/mem_align_check.sv
design/ex_stage.sv
sim/ex_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f ex_stage.f --top-module ex_stage_tb -o ex_stage_sim

out=$(./obj_dir/ex_stage_sim)
echo "$out"

if echo "$out" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1

/* sim/ex_stage_vectors.svh */
// Row columns are kind, flags {cond_branch, jump, jump_reg, stall_check}, cmp1, cmp2,
// next_pc, cache_ready and expected {jump_final, flush, squash, predicted}
task automatic load_table();
    // Taken branch rows go to the target
    add_row(br_beq,  4'b1000, 64'd5, 64'd5, TGT,  1'b1, 4'b1001);
    add_row(br_beq,  4'b1000, 64'd5, 64'd6, FALL, 1'b1, 4'b0001);
    add_row(br_bne,  4'b1000, 64'd5, 64'd6, TGT,  1'b1, 4'b1001);
    add_row(br_blt,  4'b1000, NEG1,  64'd1, TGT,  1'b1, 4'b1001);
    add_row(br_bltu, 4'b1000, NEG1,  64'd1, FALL, 1'b1, 4'b0001);
    add_row(br_bge,  4'b1000, 64'd1, NEG1,  TGT,  1'b1, 4'b1001);
    add_row(br_bge,  4'b1000, NEG1,  64'd1, FALL, 1'b1, 4'b0001);
    add_row(br_bgeu, 4'b1000, 64'd1, NEG1,  FALL, 1'b1, 4'b0001);
    add_row(br_bltu, 4'b1000, 64'd1, NEG1,  TGT,  1'b1, 4'b1001);
    add_row(br_bne,  4'b1000, 64'd5, 64'd5, FALL, 1'b1, 4'b0001);
    add_row(br_blt,  4'b1000, 64'd1, NEG1,  FALL, 1'b1, 4'b0001);
    add_row(br_bgeu, 4'b1000, NEG1,  64'd1, TGT,  1'b1, 4'b1001);
    add_row(br_kind_t'(3'd2), 4'b1000, 64'd5, 64'd5, FALL, 1'b1, 4'b0001);
    add_row(br_beq,  4'b0100, 64'd5, 64'd6, TGT,  1'b1, 4'b1001);
    add_row(br_beq,  4'b0010, 64'd5, 64'd6, TGT,  1'b1, 4'b1001);
    // Jump to the wrong next_pc starts a flush
    add_row(br_beq,  4'b0100, 64'd0, 64'd0, BAD,  1'b1, 4'b1000);
    add_row(br_beq,  4'b0100, 64'd0, 64'd0, BAD,  1'b1, 4'b0111);
    add_row(br_beq,  4'b0000, 64'd0, 64'd0, FALL, 1'b1, 4'b0111);
    // Cache stall in the middle of the flush
    add_row(br_beq,  4'b0000, 64'd0, 64'd0, FALL, 1'b0, 4'b0111);
    add_row(br_beq,  4'b0000, 64'd0, 64'd0, FALL, 1'b0, 4'b0111);
    add_row(br_beq,  4'b0000, 64'd0, 64'd0, FALL, 1'b0, 4'b0111);
    add_row(br_beq,  4'b0000, 64'd0, 64'd0, FALL, 1'b1, 4'b0111);
    add_row(br_beq,  4'b0000, 64'd0, 64'd0, FALL, 1'b1, 4'b0111);
    add_row(br_beq,  4'b0000, 64'd0, 64'd0, FALL, 1'b1, 4'b0011);
    add_row(br_beq,  4'b0000, 64'd0, 64'd0, FALL, 1'b1, 4'b0011);
    // Matching jump and then a sequential miss
    add_row(br_beq,  4'b0100, 64'd0, 64'd0, TGT,  1'b1, 4'b1001);
    add_row(br_beq,  4'b0001, 64'd0, 64'd0, SEQ_BAD, 1'b1, 4'b0000);
    add_row(br_beq,  4'b0000, 64'd0, 64'd0, FALL, 1'b1, 4'b0111);
endtask

/* sim/ex_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_stage_tb;

    import ex_stage_pkg::*;

    localparam xlen_t PC      = 64'h1000;
    localparam xlen_t OFFS    = 64'h40;
    localparam xlen_t TGT     = 64'h1040;
    localparam xlen_t FALL    = 64'h1004;
    localparam xlen_t BAD     = 64'h2000;
    localparam xlen_t SEQ_BAD = 64'h1008;
    localparam xlen_t NEG1    = '1;

    typedef struct packed
    {
        br_kind_t   kind;
        logic [3:0] flags;
        xlen_t      c1;
        xlen_t      c2;
        xlen_t      npc;
        logic       rdy;
        logic [3:0] exp;
    } row_t;

    logic CLK;
    logic RST;
    alu_op_t alu_op;
    logic word_op;
    xlen_t op_a;
    xlen_t op_b;
    xlen_t cmp1;
    xlen_t cmp2;
    xlen_t jump_base;
    xlen_t jump_offset;
    xlen_t pc_ex;
    xlen_t next_pc;
    br_kind_t br_kind;
    logic cond_branch;
    logic jump;
    logic jump_reg;
    logic stall_check;
    logic cache_ready;
    mem_ctl_t mem_ctl_in;
    mem_type_t mem_type_in;
    ldst_size_t ldst_size;
    xlen_t alu_result;
    xlen_t data_address;
    xlen_t jump_addr;
    logic jump_final;
    logic flush;
    logic squash;
    logic predicted;
    mem_ctl_t mem_ctl;
    mem_type_t mem_type;
    logic word_op_out;
    logic load_misaligned;
    logic store_misaligned;
    logic load_word;

    row_t        rows[$];
    logic [31:0] rng = 32'd32811;
    int          tests = 0;
    int          failures = 0;
    logic        row_bad;

    ex_stage ex_stage_inst
    (
        .CLK(CLK), .RST(RST), .alu_op(alu_op), .word_op(word_op),
        .op_a(op_a), .op_b(op_b), .cmp1(cmp1), .cmp2(cmp2),
        .jump_base(jump_base), .jump_offset(jump_offset), .pc_ex(pc_ex),
        .next_pc(next_pc), .br_kind(br_kind), .cond_branch(cond_branch),
        .jump(jump), .jump_reg(jump_reg), .stall_check(stall_check),
        .cache_ready(cache_ready), .mem_ctl_in(mem_ctl_in),
        .mem_type_in(mem_type_in), .ldst_size(ldst_size),
        .alu_result(alu_result), .data_address(data_address),
        .jump_addr(jump_addr), .jump_final(jump_final), .flush(flush),
        .squash(squash), .predicted(predicted), .mem_ctl(mem_ctl),
        .mem_type(mem_type), .word_op_out(word_op_out),
        .load_misaligned(load_misaligned), .store_misaligned(store_misaligned),
        .load_word(load_word)
    );

    task automatic add_row(br_kind_t kind, logic [3:0] flags, xlen_t c1, xlen_t c2,
                           xlen_t npc, logic rdy, logic [3:0] exp);
        rows.push_back({kind, flags, c1, c2, npc, rdy, exp});
    endtask

    `include "ex_stage_vectors.svh"

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic xlen_t rand64();
        xlen_t v;
        rng = xorshift(rng);
        v[63:32] = rng;
        rng = xorshift(rng);
        v[31:0] = rng;
        return v;
    endfunction

    // Reference ALU; subtraction and compares take b against a
    function automatic xlen_t alu_model(alu_op_t op, logic w, xlen_t a, xlen_t b);
        xlen_t       r;
        logic [31:0] lo;
        case (op)
            alu_add:    r = a + b;
            alu_sub:    r = b - a;
            alu_sll:    r = b << a[5:0];
            alu_srl:    r = b >> a[5:0];
            alu_sra:    r = $signed(b) >>> a[5:0];
            alu_xor:    r = a ^ b;
            alu_or:     r = a | b;
            alu_and:    r = a & b;
            alu_pass_a: r = a;
            alu_pass_b: r = b;
            alu_slt:    r = ($signed(b) < $signed(a)) ? 64'd1 : 64'd0;
            alu_sltu:   r = (b < a) ? 64'd1 : 64'd0;
            alu_b4:     r = b + 64'd4;
            default:    r = '0;
        endcase
        // Word results from the low halves
        case (op)
            alu_add: lo = a[31:0] + b[31:0];
            alu_sub: lo = b[31:0] - a[31:0];
            alu_sll: lo = b[31:0] << a[4:0];
            alu_srl: lo = b[31:0] >> a[4:0];
            alu_sra: lo = $signed(b[31:0]) >>> a[4:0];
            default: lo = '0;
        endcase
        if (w && op >= alu_add && op <= alu_sra)
            r = {{32{lo[31]}}, lo};
        return r;
    endfunction

    function automatic logic misaligned_model(ldst_size_t size, logic [2:0] low);
        case (size)
            ls_half, ls_uhalf: return low == 3'd7;
            ls_word, ls_uword: return low > 3'd4;
            ls_double:         return low != 3'd0;
            default:           return 1'b0;
        endcase
    endfunction

    task automatic check_val(string sig, logic [63:0] exp, logic [63:0] act);
        if (act !== exp)
        begin
            $display("ERROR %s expected %h actual %h", sig, exp, act);
            row_bad = 1'b1;
        end
    endtask

    // exp is {jump_final, flush, squash, predicted}
    task automatic check_outputs(string name, logic [3:0] exp);
        xlen_t addr;
        logic  mis;
        #5;
        row_bad = 1'b0;
        addr = op_a + op_b;
        mis  = misaligned_model(ldst_size, addr[2:0]);
        check_val("alu_result", alu_model(alu_op, word_op, op_a, op_b), alu_result);
        check_val("data_address", addr, data_address);
        check_val("jump_addr", jump_base + jump_offset, jump_addr);
        check_val("jump_final", 64'(exp[3]), 64'(jump_final));
        check_val("flush", 64'(exp[2]), 64'(flush));
        check_val("squash", 64'(exp[1]), 64'(squash));
        check_val("predicted", 64'(exp[0]), 64'(predicted));
        check_val("mem_ctl", exp[1] ? 64'd0 : 64'(mem_ctl_in), 64'(mem_ctl));
        check_val("mem_type", exp[1] ? 64'd0 : 64'(mem_type_in), 64'(mem_type));
        check_val("word_op_out", 64'(word_op & !exp[1]), 64'(word_op_out));
        check_val("load_misaligned", 64'(mis && mem_ctl_in == mem_load), 64'(load_misaligned));
        check_val("store_misaligned", 64'(mis && mem_ctl_in == mem_store),
                  64'(store_misaligned));
        check_val("load_word", 64'(ldst_size != ls_double), 64'(load_word));
        tests++;
        if (row_bad)
            failures++;
        $display("%s %s", name, row_bad ? "FAIL" : "ok");
        @(posedge CLK);
        #1;
    endtask

    task automatic set_idle();
        alu_op = alu_idle;
        word_op = 1'b0;
        op_a = '0;
        op_b = '0;
        cmp1 = '0;
        cmp2 = '0;
        jump_base = PC;
        jump_offset = OFFS;
        pc_ex = PC;
        next_pc = FALL;
        br_kind = br_beq;
        {cond_branch, jump, jump_reg, stall_check} = 4'b0000;
        cache_ready = 1'b1;
        mem_ctl_in = mem_none;
        mem_type_in = 2'b11;
        ldst_size = ls_byte;
    endtask

    initial
    begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    initial
    begin
        int wait_cnt;
        RST = 1'b1;
        set_idle();
        load_table();
        repeat (16) @(posedge CLK);
        #1;
        RST = 1'b0;

        ////////////////////////////////////////////////////////////
        // ALU on random operands in both widths
        for (int w = 0; w < 2; w++)
            for (int op = 0; op < 14; op++)
            begin
                alu_op = alu_op_t'(4'(op));
                word_op = 1'(w);
                op_a = rand64();
                op_b = rand64();
                check_outputs($sformatf("alu op %0d word %0d", op, w), 4'b0001);
            end
        set_idle();

        ////////////////////////////////////////////////////////////
        // Misalignment over every size and low address pattern
        for (int c = 0; c < 3; c++)
            for (int s = 0; s < 6; s++)
                for (int l = 0; l < 8; l++)
                begin
                    mem_ctl_in = mem_ctl_t'(2'(c));
                    ldst_size = ldst_size_t'(3'(s));
                    op_a = 64'h2000;
                    op_b = {61'd0, 3'(l)};
                    check_outputs($sformatf("align ctl %0d size %0d low %0d", c, s, l),
                                  4'b0001);
                end
        set_idle();

        ////////////////////////////////////////////////////////////
        // Branch and flush table
        word_op = 1'b1;
        mem_ctl_in = mem_load;
        foreach (rows[i])
        begin
            br_kind = rows[i].kind;
            {cond_branch, jump, jump_reg, stall_check} = rows[i].flags;
            cmp1 = rows[i].c1;
            cmp2 = rows[i].c2;
            next_pc = rows[i].npc;
            cache_ready = rows[i].rdy;
            check_outputs($sformatf("table row %0d", i), rows[i].exp);
        end
        set_idle();

        wait_cnt = 0;
        while (squash === 1'b1 && wait_cnt < 20)
        begin
            @(posedge CLK);
            #1;
            wait_cnt++;
        end

        if (squash !== 1'b0)
        begin
            $display("Timeout: squash did not clear after the last flush");
            $display("Tests %0d, failed %0d", tests, failures);
            $display("Verification failed");
        end
        else
        begin
            $display("Tests %0d, failed %0d", tests, failures);
            if (failures == 0)
                $display("Verification passed");
            else
                $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
